//--- src.f
hdl/gfx_mem_pkg.sv
hdl/gfx_skid_buf.sv
hdl/gfx_pipes.sv
hdl/gfx_mem_arbiter.sv
hdl/gfx_mem_trans_path.sv
hdl/gfx_mem_dispatch.sv
hdl/gfx_mem.sv
verification/gfx_mem_properties.sv
verification/gfx_mem_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module gfx_mem_tb \
	-f src.f \
	-o gfx_mem_sim

./obj_dir/gfx_mem_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
grep -q "TEST PASSED" sim.log

//--- verification/gfx_mem_tb.sv
`timescale 1ns/1ps

module gfx_mem_tb
	import gfx_mem_pkg::*;
();

	localparam int TRANS_DEPTH    = 2;
	localparam int RESPONSE_DEPTH = 2;
	localparam int DISPATCH_DEPTH = 8;
	localparam int NUM_REQ        = 400;

	typedef struct packed {
		vram_byte_addr address;
		logic          write;
		vram_word      data;
	} vram_cmd;

	logic clk, rst_n;
	logic mem_waitrequest, mem_readdatavalid, mem_read, mem_write;
	vram_word mem_readdata, mem_writedata;
	vram_byte_addr mem_address;
	logic rop_write, fb_read, batch_read, fetch_read;
	logic rop_waitrequest, fb_waitrequest, batch_waitrequest, fetch_waitrequest;
	logic fb_readdatavalid, batch_readdatavalid, fetch_readdatavalid;
	vram_word rop_writedata, fb_readdata, batch_readdata, fetch_readdata;
	half_coord rop_address, fb_address;
	vram_addr batch_address, fetch_address;

	// Client index 0 to 3 is fb, batch, rop and fetch in priority order.
	logic [3:0] req, wreq, acc;
	vram_addr addr[4];
	vram_word wdata;
	logic [31:0] lfsr = 32'h936f_ba04;
	int cycle, started, outstanding;
	int full_writes;
	logic idle_phase;
	vram_word ref_mem[256];
	vram_word vram[256];
	vram_cmd cmd_q[$];
	vram_word exp_q[3][$];
	vram_word resp_q[$];
	int resp_due[$];
	int lat_q[$];
	int last_due;

	assign fb_read = req[0];
	assign fb_address = half_coord'(addr[0]);
	assign batch_read = req[1];
	assign batch_address = addr[1];
	assign rop_write = req[2];
	assign rop_address = half_coord'(addr[2]);
	assign rop_writedata = wdata;
	assign fetch_read = req[3];
	assign fetch_address = addr[3];
	assign wreq = {fetch_waitrequest, rop_waitrequest, batch_waitrequest, fb_waitrequest};

	gfx_mem #(
		.TRANS_DEPTH    (TRANS_DEPTH),
		.RESPONSE_DEPTH (RESPONSE_DEPTH),
		.DISPATCH_DEPTH (DISPATCH_DEPTH)
	) dut (.*);

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic vram_word fill_word(input int i);
		return vram_word'(i * 40503) ^ 16'h5a3c;
	endfunction

	// Every read sees the last write accepted before it.
	function automatic vram_word expected_read(input vram_addr a);
		return ref_mem[a[7:0]];
	endfunction

	task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("TEST FAILED");
		$fatal(1, "error %s: got %h, expected %h", name, got, exp);
	endtask

	task automatic fail_plain(input string msg);
		$display("TEST FAILED");
		$fatal(1, "%s", msg);
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = 1'b1;
			cycle++;
			#2 clk = 1'b0;
		end
	end

	initial begin
		repeat (NUM_REQ * 40 + 200) @(posedge clk);
		fail_plain("watchdog expired before all requests completed");
	end

	initial begin
		vram_addr a;
		rst_n = 1'b0;
		req = '0;
		wdata = '0;
		idle_phase = 1'b1;
		for (int i = 0; i < 4; i++)
			addr[i] = '0;
		for (int i = 0; i < 256; i++) begin
			ref_mem[i] = fill_word(i);
			vram[i] = fill_word(i);
		end
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;
		repeat (8) @(posedge clk);
		#1 idle_phase = 1'b0;
		while (started < NUM_REQ) begin
			@(posedge clk);
			#1;
			for (int i = 0; i < 4; i++) begin
				if (acc[i])
					req[i] = 1'b0;
				if (!req[i] && started < NUM_REQ && rand_bits(2) != 0) begin
					a = vram_addr'(rand_bits(25));
					a[7:4] = 4'h0; // A small window so reads hit earlier writes.
					if (i == 0 || i == 2)
						a[24:20] = '0;
					addr[i] = a;
					if (i == 2)
						wdata = vram_word'(rand_bits(16));
					req[i] = 1'b1;
					started++;
				end
			end
		end
		@(posedge clk);
		#1;
		for (int i = 0; i < 4; i++)
			if (acc[i])
				req[i] = 1'b0;
		while (req != 0 || cmd_q.size() != 0 || outstanding != 0 || exp_q[0].size() != 0
			|| exp_q[1].size() != 0 || exp_q[2].size() != 0) begin
			@(posedge clk);
			#1;
			for (int i = 0; i < 4; i++)
				if (acc[i])
					req[i] = 1'b0;
		end
		repeat (5) @(posedge clk);
		assert (full_writes != 0)
			else fail_plain("no write reached VRAM while the tag queue was full");
		$display("TEST PASSED");
		$finish;
	end

	// The VRAM model stalls at random and answers reads in order after a random latency.
	initial begin
		logic stall_next;
		mem_waitrequest = 1'b0;
		mem_readdatavalid = 1'b0;
		mem_readdata = '0;
		forever begin
			@(negedge clk);
			stall_next = rand_bits(2) == 0;
			@(posedge clk);
			#1;
			mem_waitrequest = stall_next;
			mem_readdatavalid = 1'b0;
			if (resp_q.size() != 0 && resp_due[0] <= cycle) begin
				mem_readdatavalid = 1'b1;
				mem_readdata = resp_q.pop_front();
				void'(resp_due.pop_front());
			end
		end
	end

	// Watches client acceptances and VRAM commands just after the falling edge.
	initial begin
		vram_cmd c;
		int lat;
		forever begin
			@(negedge clk);
			#0.5;
			acc = '0;
			if (rst_n) begin
				if (idle_phase)
					assert (!mem_read && !mem_write)
						else fail_plain("VRAM command appeared while all clients were idle");
				for (int i = 0; i < 4; i++) begin
					if (!wreq[i]) begin
						assert (req[i] && (req & 4'((1 << i) - 1)) == 4'b0)
							else fail_plain("waitrequest low for a client without priority");
						acc[i] = 1'b1;
						c.address = {addr[i], 1'b0};
						c.write = i == 2;
						c.data = wdata;
						cmd_q.push_back(c);
						if (i == 2)
							ref_mem[addr[i][7:0]] = wdata;
						else
							exp_q[i == 3 ? 2 : i].push_back(expected_read(addr[i]));
					end
				end
				if ((mem_read || mem_write) && !mem_waitrequest) begin
					assert (cmd_q.size() != 0)
						else fail_plain("VRAM command without an accepted client request");
					c = cmd_q.pop_front();
					assert (mem_address == c.address)
						else fail_value("mem_address", 32'(mem_address), 32'(c.address));
					assert (mem_write == c.write)
						else fail_value("mem_write", 32'(mem_write), 32'(c.write));
					assert (mem_read == !c.write)
						else fail_value("mem_read", 32'(mem_read), 32'(!c.write));
					if (mem_write) begin
						assert (mem_writedata == c.data)
							else fail_value("mem_writedata", 32'(mem_writedata), 32'(c.data));
						vram[mem_address[8:1]] = mem_writedata;
						if (outstanding == DISPATCH_DEPTH - 1)
							full_writes++; // Reads are blocked by a full tag queue here.
					end else begin
						lat = started >= NUM_REQ / 2 ? 12 + int'(rand_bits(2)) : 1 + int'(rand_bits(2));
						last_due = (cycle + lat > last_due) ? cycle + lat : last_due + 1;
						resp_q.push_back(vram[mem_address[8:1]]);
						resp_due.push_back(last_due);
						outstanding++;
						assert (outstanding <= DISPATCH_DEPTH - 1)
							else fail_plain("more reads outstanding than the tag queue can hold");
					end
				end
			end
		end
	end

	// Compares each client response with the reference prediction.
	initial begin
		logic [2:0] v;
		vram_word got, exp;
		int t;
		forever begin
			@(negedge clk);
			if (mem_readdatavalid)
				lat_q.push_back(cycle);
			v = {fetch_readdatavalid, batch_readdatavalid, fb_readdatavalid};
			assert ($onehot0(v))
				else fail_plain("more than one client readdatavalid pulsed in the same cycle");
			for (int k = 0; k < 3; k++) begin
				if (v[k]) begin
					assert (exp_q[k].size() != 0 && lat_q.size() != 0)
						else fail_plain("read response for a client with no pending read");
					exp = exp_q[k].pop_front();
					got = k == 0 ? fb_readdata : (k == 1 ? batch_readdata : fetch_readdata);
					assert (got == exp) else fail_value("readdata", 32'(got), 32'(exp));
					t = lat_q.pop_front();
					assert (cycle - t == RESPONSE_DEPTH + 1)
						else fail_value("response latency", 32'(cycle - t), RESPONSE_DEPTH + 1);
					outstanding--;
				end
			end
		end
	end

endmodule

//--- verification/gfx_mem_properties.sv
`timescale 1ns/1ps

module gfx_mem_properties #(
	parameter int PTR_BITS = 3
) (
	input logic                clk,
	input logic                rst_n,
	input logic                tag_put,
	input logic                tag_full,
	input logic                resp_valid,
	input logic                fb_readdatavalid,
	input logic                batch_readdatavalid,
	input logic                fetch_readdatavalid,
	input logic [PTR_BITS-1:0] put_ptr,
	input logic [PTR_BITS-1:0] pop_ptr
);

	// A response belongs to exactly one client.
	one_owner: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({fb_readdatavalid, batch_readdatavalid, fetch_readdatavalid}))
		else $error("more than one client readdatavalid is high");

	no_put_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		tag_put |-> !tag_full)
		else $error("tag pushed into a full tag queue");

	// The queue cannot be empty while a response leaves the pipe.
	tag_pending: assert property (@(posedge clk) disable iff (!rst_n)
		resp_valid |-> put_ptr != pop_ptr)
		else $error("read response arrived without a pending tag");

endmodule

bind gfx_mem_dispatch gfx_mem_properties #(.PTR_BITS(PTR_BITS)) props (
	.clk                 (clk),
	.rst_n               (rst_n),
	.tag_put             (tag_put),
	.tag_full            (tag_full),
	.resp_valid          (resp_valid),
	.fb_readdatavalid    (fb_readdatavalid),
	.batch_readdatavalid (batch_readdatavalid),
	.fetch_readdatavalid (fetch_readdatavalid),
	.put_ptr             (put_ptr),
	.pop_ptr             (pop_ptr)
);

//--- hdl/gfx_mem.sv
`timescale 1ns/1ps

module gfx_mem
	import gfx_mem_pkg::*;
#(
	parameter int TRANS_DEPTH    = 2,
	parameter int RESPONSE_DEPTH = 2,
	parameter int DISPATCH_DEPTH = 8
) (
	input  logic          clk,
	input  logic          rst_n,

	input  logic          mem_waitrequest,
	input  logic          mem_readdatavalid,
	input  vram_word      mem_readdata,
	output vram_byte_addr mem_address,
	output logic          mem_read,
	output logic          mem_write,
	output vram_word      mem_writedata,

	input  logic          rop_write,
	input  vram_word      rop_writedata,
	input  half_coord     rop_address,
	output logic          rop_waitrequest,

	input  logic          fb_read,
	input  half_coord     fb_address,
	output logic          fb_waitrequest,
	output logic          fb_readdatavalid,
	output vram_word      fb_readdata,

	input  logic          batch_read,
	input  vram_addr      batch_address,
	output logic          batch_waitrequest,
	output logic          batch_readdatavalid,
	output vram_word      batch_readdata,

	input  logic          fetch_read,
	input  vram_addr      fetch_address,
	output logic          fetch_waitrequest,
	output logic          fetch_readdatavalid,
	output vram_word      fetch_readdata
);

	mem_trans trans;
	logic     trans_valid;
	logic     trans_ready;
	logic     tag_full;
	logic     tag_put;
	mem_tag   tag;
	vram_word readdata;

	// All three read clients share one data bus. Only the valids are routed.
	assign fb_readdata = readdata;
	assign batch_readdata = readdata;
	assign fetch_readdata = readdata;

	gfx_mem_arbiter arbiter (.*);

	gfx_mem_trans_path #(.TRANS_DEPTH(TRANS_DEPTH)) trans_path (.*);

	gfx_mem_dispatch #(
		.RESPONSE_DEPTH (RESPONSE_DEPTH),
		.DISPATCH_DEPTH (DISPATCH_DEPTH)
	) dispatch (.*);

endmodule

//--- hdl/gfx_mem_dispatch.sv
`timescale 1ns/1ps

module gfx_mem_dispatch
	import gfx_mem_pkg::*;
#(
	parameter int RESPONSE_DEPTH = 2,
	parameter int DISPATCH_DEPTH = 8
) (
	input  logic     clk,
	input  logic     rst_n,

	input  logic     tag_put,
	input  mem_tag   tag,
	output logic     tag_full,

	input  logic     mem_readdatavalid,
	input  vram_word mem_readdata,

	output logic     fb_readdatavalid,
	output logic     batch_readdatavalid,
	output logic     fetch_readdatavalid,
	output vram_word readdata
);

	localparam int PTR_BITS = $clog2(DISPATCH_DEPTH);

	mem_tag                tag_queue[DISPATCH_DEPTH];
	mem_tag                owner;
	logic   [PTR_BITS-1:0] put_ptr;
	logic   [PTR_BITS-1:0] pop_ptr;
	logic   [PTR_BITS-1:0] next_put_ptr;
	vram_word              resp_data;
	logic                  resp_valid;
	logic                  any_valid;

	// One slot stays empty so that full and empty differ.
	assign next_put_ptr = put_ptr + 1'b1;
	assign tag_full = next_put_ptr == pop_ptr;

	assign fb_readdatavalid = any_valid && owner.fb;
	assign batch_readdatavalid = any_valid && owner.batch;
	assign fetch_readdatavalid = any_valid && owner.fetch;

	// Responses come back in issue order, so nothing here ever waits.
	gfx_pipes #(.T(vram_word), .DEPTH(RESPONSE_DEPTH)) resp_pipes (
		.clk       (clk),
		.rst_n     (rst_n),
		.in        (mem_readdata),
		.in_valid  (mem_readdatavalid),
		.stall     (1'b0),
		.out       (resp_data),
		.out_valid (resp_valid)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			put_ptr <= '0;
			pop_ptr <= '0;
			any_valid <= 1'b0;
		end else begin
			any_valid <= resp_valid;

			if (tag_put)
				put_ptr <= next_put_ptr;

			if (resp_valid)
				pop_ptr <= pop_ptr + 1'b1;
		end
	end

	// The owner is read ahead of time and lines up with the registered data.
	always_ff @(posedge clk) begin
		readdata <= resp_data;
		owner <= tag_queue[pop_ptr];

		if (tag_put)
			tag_queue[put_ptr] <= tag;
	end

endmodule

//--- hdl/gfx_mem_trans_path.sv
`timescale 1ns/1ps

module gfx_mem_trans_path
	import gfx_mem_pkg::*;
#(
	parameter int TRANS_DEPTH = 2
) (
	input  logic          clk,
	input  logic          rst_n,

	input  mem_trans      trans,
	input  logic          trans_valid,
	output logic          trans_ready,

	input  logic          tag_full,

	input  logic          mem_waitrequest,
	output vram_byte_addr mem_address,
	output logic          mem_read,
	output logic          mem_write,
	output vram_word      mem_writedata,

	output logic          tag_put,
	output mem_tag        tag
);

	mem_trans pipe_out;
	mem_trans head;
	logic     pipe_valid;
	logic     pipe_stall;
	logic     skid_ready;
	logic     head_valid;
	logic     head_issue;

	// The whole pipe holds once its last item cannot enter the output skid.
	assign pipe_stall = pipe_valid && !skid_ready;
	assign trans_ready = !pipe_stall;

	// A read also needs room in the tag queue. Writes never wait on it.
	assign head_issue = !mem_waitrequest && (head.write || !tag_full);

	assign mem_read = head_valid && !head.write && !tag_full;
	assign mem_write = head_valid && head.write;
	assign mem_address = {head.address, {gfx_mem_subword_bits{1'b0}}};
	assign mem_writedata = head.writedata;

	assign tag_put = mem_read && !mem_waitrequest;
	assign tag = head.tag;

	gfx_pipes #(.T(mem_trans), .DEPTH(TRANS_DEPTH)) trans_pipes (
		.clk       (clk),
		.rst_n     (rst_n),
		.in        (trans),
		.in_valid  (trans_valid),
		.stall     (pipe_stall),
		.out       (pipe_out),
		.out_valid (pipe_valid)
	);

	// Registers the pins toward VRAM, which sit far away at the edge of the die.
	gfx_skid_buf #(.T(mem_trans)) out_skid (
		.clk       (clk),
		.rst_n     (rst_n),
		.in        (pipe_out),
		.in_valid  (pipe_valid),
		.in_ready  (skid_ready),
		.out       (head),
		.out_valid (head_valid),
		.out_ready (head_issue)
	);

endmodule

//--- hdl/gfx_mem_arbiter.sv
`timescale 1ns/1ps

module gfx_mem_arbiter
	import gfx_mem_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  logic      rop_write,
	input  vram_word  rop_writedata,
	input  half_coord rop_address,
	output logic      rop_waitrequest,

	input  logic      fb_read,
	input  half_coord fb_address,
	output logic      fb_waitrequest,

	input  logic      batch_read,
	input  vram_addr  batch_address,
	output logic      batch_waitrequest,

	input  logic      fetch_read,
	input  vram_addr  fetch_address,
	output logic      fetch_waitrequest,

	output mem_trans  trans,
	output logic      trans_valid,
	input  logic      trans_ready
);

	mem_trans req;
	logic     req_valid;
	logic     in_ready;

	assign req_valid = fb_read || batch_read || rop_write || fetch_read;

	// Fixed priority keeps scanout from starving, and shader fetch takes what is left.
	always_comb begin
		fb_waitrequest = 1'b1;
		batch_waitrequest = 1'b1;
		rop_waitrequest = 1'b1;
		fetch_waitrequest = 1'b1;

		req.address = fetch_address;
		req.write = 1'b0;
		req.tag = '0;
		req.writedata = rop_writedata;

		if (fb_read) begin
			fb_waitrequest = !in_ready;
			req.address = vram_addr'(fb_address);
			req.tag.fb = 1'b1;
		end else if (batch_read) begin
			batch_waitrequest = !in_ready;
			req.address = batch_address;
			req.tag.batch = 1'b1;
		end else if (rop_write) begin
			rop_waitrequest = !in_ready;
			req.address = vram_addr'(rop_address);
			req.write = 1'b1;
		end else if (fetch_read) begin
			fetch_waitrequest = !in_ready;
			req.tag.fetch = 1'b1;
		end
	end

	gfx_skid_buf #(.T(mem_trans)) in_skid (
		.clk       (clk),
		.rst_n     (rst_n),
		.in        (req),
		.in_valid  (req_valid),
		.in_ready  (in_ready),
		.out       (trans),
		.out_valid (trans_valid),
		.out_ready (trans_ready)
	);

endmodule

//--- hdl/gfx_pipes.sv
`timescale 1ns/1ps

module gfx_pipes #(
	parameter type T = logic,
	parameter int  DEPTH = 2
) (
	input  logic clk,
	input  logic rst_n,

	input  T     in,
	input  logic in_valid,
	input  logic stall,

	output T     out,
	output logic out_valid
);

	T     stage[DEPTH];
	logic [DEPTH-1:0] stage_valid;

	assign out = stage[DEPTH-1];
	assign out_valid = stage_valid[DEPTH-1];

	// Each item keeps its valid bit beside it, so bubbles travel too.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage_valid <= '0;
		end else if (!stall) begin
			stage_valid[0] <= in_valid;
			for (int i = 1; i < DEPTH; i++)
				stage_valid[i] <= stage_valid[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			stage[0] <= in;
			for (int i = 1; i < DEPTH; i++)
				stage[i] <= stage[i-1];
		end
	end

endmodule

//--- hdl/gfx_skid_buf.sv
`timescale 1ns/1ps

module gfx_skid_buf #(
	parameter type T = logic
) (
	input  logic clk,
	input  logic rst_n,

	input  T     in,
	input  logic in_valid,
	output logic in_ready,

	output T     out,
	output logic out_valid,
	input  logic out_ready
);

	T     spare;
	logic spare_valid;
	logic out_free;

	// The output register may load when it is empty or being consumed.
	assign out_free = out_ready || !out_valid;

	// Ready comes straight from a flop, so it never follows out_ready in the same cycle.
	assign in_ready = !spare_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			spare_valid <= 1'b0;
		end else if (out_free) begin
			out_valid <= spare_valid || in_valid; // The spare drains first.
			spare_valid <= 1'b0;
		end else if (in_valid && !spare_valid) begin
			spare_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (out_free)
			out <= spare_valid ? spare : in;

		// Harmless when the output moves, since spare_valid stays low then.
		if (in_ready)
			spare <= in;
	end

endmodule

//--- hdl/gfx_mem_pkg.sv
package gfx_mem_pkg;

	// One VRAM data word.
	typedef logic [15:0] vram_word;

	// Word address into VRAM.
	typedef logic [24:0] vram_addr;

	// Pixel index from the raster-op unit and the scanout, zero-extended to a vram_addr.
	typedef logic [19:0] half_coord;

	// Byte-address bits below one word.
	localparam int gfx_mem_subword_bits = 1;

	// Byte address as it appears on the VRAM bus.
	typedef logic [$bits(vram_addr) + gfx_mem_subword_bits - 1:0] vram_byte_addr;

	// One-hot owner of a read. A write carries an all-zero tag.
	typedef struct packed {
		logic fb;
		logic batch;
		logic fetch;
	} mem_tag;

	// A single VRAM transaction as it travels from the arbiter to the VRAM port.
	typedef struct packed {
		vram_addr address;
		logic     write;
		mem_tag   tag;
		vram_word writedata;
	} mem_trans;

endpackage
